//--- common/drumPkg.sv
`default_nettype none

package drumPkg;

  // Displacements and coefficients in 1.17 fixed point
  typedef logic signed [17:0] sample_t;

  // Sequencer phase, broadcast to every node of the mesh
  typedef enum logic [2:0] {
    phaseIdle   = 3'd0,
    phaseClear  = 3'd1,
    phaseStrike = 3'd2,
    phaseMul0   = 3'd3,
    phaseMul1   = 3'd4,
    phaseMul2   = 3'd5,
    phaseCommit = 3'd6
  } phase_t;

  // Strike register, written as a bus word and read back as fields
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [5:0] spare;
      logic [3:0] yIndex;
      logic [3:0] xIndex;
      sample_t    amp;
    } fields;
  } strikeWord_t;

  // Byte offsets of the host registers
  localparam logic [11:0] regCtrl     = 12'h000;
  localparam logic [11:0] regSteps    = 12'h004;
  localparam logic [11:0] regStrike   = 12'h008;
  localparam logic [11:0] regRho      = 12'h00C;
  localparam logic [11:0] regEta      = 12'h010;
  localparam logic [11:0] regStatus   = 12'h014;
  localparam logic [11:0] regNodeBase = 12'h040;

  typedef logic [1:0] axiResp_t;
  localparam axiResp_t respOkay = 2'b00;

endpackage

`default_nettype wire

//--- mesh/compNode.sv
`default_nettype none

module compNode
(
  input  logic             clk,
  input  logic             reset,
  input  drumPkg::phase_t  phase,
  input  drumPkg::sample_t uNorth,
  input  drumPkg::sample_t uSouth,
  input  drumPkg::sample_t uEast,
  input  drumPkg::sample_t uWest,
  input  drumPkg::sample_t rho,
  input  drumPkg::sample_t oneMinusEta,
  input  logic             strikeHit,
  input  drumPkg::sample_t strikeAmp,
  output drumPkg::sample_t u
);
  import drumPkg::*;

  sample_t            lap;
  sample_t            opA;
  sample_t            opB;
  logic signed [35:0] fullProduct;
  sample_t            product;
  sample_t            p0;
  sample_t            p1;
  sample_t            p2;
  sample_t            uPrev;
  sample_t            uNext;

  // Discrete Laplacian, wraps at 18 bits
  assign lap = uNorth + uSouth + uEast + uWest - (u <<< 2);

  // Operand A is rho only in the first phase
  assign opA = (phase == phaseMul0) ? rho : oneMinusEta;

  always_comb
  begin
    case (phase)
      phaseMul1: opB = p0;
      phaseMul2: opB = uPrev;
      default:   opB = lap;
    endcase
  end

  // One shared multiplier, result rescaled back to 1.17
  assign fullProduct = opA * opB;
  assign product     = fullProduct[34:17];

  assign uNext = p1 + (u <<< 1) - p2;

  always_ff @(posedge clk)
  begin
    case (phase)
      phaseMul0: p0 <= product;
      phaseMul1: p1 <= product;
      phaseMul2: p2 <= product;
      default:   ;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      u     <= '0;
      uPrev <= '0;
    end
    else
    begin
      case (phase)
        phaseClear:
        begin
          u     <= '0;
          uPrev <= '0;
        end
        phaseStrike:
        begin
          // Only the addressed node takes the amplitude
          if (strikeHit)
            u <= strikeAmp;
        end
        phaseCommit:
        begin
          uPrev <= u;
          u     <= uNext;
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- mesh/nodeArray.sv
`default_nettype none

module nodeArray
#(
  parameter int gridSize = 4
)(
  input  logic             clk,
  input  logic             reset,
  input  drumPkg::phase_t  phase,
  input  drumPkg::sample_t rho,
  input  drumPkg::sample_t eta,
  input  logic [3:0]       strikeX,
  input  logic [3:0]       strikeY,
  input  drumPkg::sample_t strikeAmp,
  input  logic [7:0]       readIndex,
  output drumPkg::sample_t readSample
);
  import drumPkg::*;

  localparam int nodeCount = gridSize * gridSize;

  // Grid with a ring of zeros around it for the clamped edges
  sample_t            uPad [gridSize+2][gridSize+2];
  sample_t            uFlat [nodeCount];
  logic signed [19:0] etaComplement;
  sample_t            oneMinusEta;

  // The largest 1.17 value stands in for 1.0 and above
  assign etaComplement = 20'sh20000 - {{2{eta[17]}}, eta};
  assign oneMinusEta   = (etaComplement > 20'sh1FFFF) ? 18'sh1FFFF : etaComplement[17:0];

  for (genvar r = 0; r < gridSize + 2; r++)
  begin : gPadRow
    for (genvar c = 0; c < gridSize + 2; c++)
    begin : gPadCol
      if (r == 0 || c == 0 || r == gridSize + 1 || c == gridSize + 1)
      begin : gEdge
        assign uPad[r][c] = '0;
      end
    end
  end

  for (genvar y = 0; y < gridSize; y++)
  begin : gRow
    for (genvar x = 0; x < gridSize; x++)
    begin : gCol
      logic strikeHit;

      assign strikeHit = (strikeX == 4'(x)) && (strikeY == 4'(y));
      assign uFlat[y*gridSize + x] = uPad[y+1][x+1];

      compNode node0
      (
        .clk,
        .reset,
        .phase,
        .uNorth      (uPad[y][x+1]),
        .uSouth      (uPad[y+2][x+1]),
        .uEast       (uPad[y+1][x+2]),
        .uWest       (uPad[y+1][x]),
        .rho,
        .oneMinusEta,
        .strikeHit,
        .strikeAmp,
        .u           (uPad[y+1][x+1])
      );
    end
  end

  // Indices past the grid read zero
  always_comb
  begin
    readSample = '0;
    for (int i = 0; i < nodeCount; i++)
    begin
      if (readIndex == 8'(i))
        readSample = uFlat[i];
    end
  end

endmodule

`default_nettype wire

//--- hdl/stepTimer.sv
`default_nettype none

module stepTimer
(
  input  logic        clk,
  input  logic        reset,
  input  logic        timerLoad,
  input  logic [15:0] loadValue,
  input  logic        timerDec,
  output logic [15:0] remaining,
  output logic        timerZero
);

  always_ff @(posedge clk)
  begin
    if (reset)
      remaining <= '0;
    else if (timerLoad)
      remaining <= loadValue;
    else if (timerDec && remaining != 16'd0)
      remaining <= remaining - 16'd1;
  end

  // High when the count is, or is about to become, zero
  assign timerZero = (remaining == 16'd0) || (timerDec && remaining == 16'd1);

endmodule

`default_nettype wire

//--- hdl/meshSequencer.sv
`default_nettype none

module meshSequencer
#(
  parameter int gridSize = 4
)(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 clearReq,
  input  logic                 strikeReq,
  input  logic                 stepReq,
  input  drumPkg::strikeWord_t strikeWord,
  input  logic                 timerZero,
  output drumPkg::phase_t      phase,
  output logic [3:0]           strikeX,
  output logic [3:0]           strikeY,
  output drumPkg::sample_t     strikeAmp,
  output logic                 timerLoad,
  output logic                 timerDec,
  output logic                 busy
);
  import drumPkg::*;

  phase_t state;
  logic   strikeInRange;

  assign phase = state;
  assign busy  = (state != phaseIdle);

  assign strikeInRange = (strikeWord.fields.xIndex < gridSize) &&
                         (strikeWord.fields.yIndex < gridSize);

  // Step run starts only if nothing of higher priority is asked for
  assign timerLoad = (state == phaseIdle) && stepReq && !clearReq && !strikeReq;
  assign timerDec  = (state == phaseCommit);

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= phaseIdle;
    else
    begin
      case (state)
        phaseIdle:
        begin
          if (clearReq)
            state <= phaseClear;
          else if (strikeReq)
            state <= strikeInRange ? phaseStrike : phaseIdle;
          else if (stepReq)
            state <= phaseMul0;
        end
        phaseMul0:   state <= phaseMul1;
        phaseMul1:   state <= phaseMul2;
        phaseMul2:   state <= phaseCommit;
        phaseCommit: state <= timerZero ? phaseIdle : phaseMul0;
        default:     state <= phaseIdle;
      endcase
    end
  end

  // Hold the strike target for the strike cycle
  always_ff @(posedge clk)
  begin
    if (state == phaseIdle && strikeReq)
    begin
      strikeX   <= strikeWord.fields.xIndex;
      strikeY   <= strikeWord.fields.yIndex;
      strikeAmp <= strikeWord.fields.amp;
    end
  end

endmodule

`default_nettype wire

//--- hdl/axiLiteRegs.sv
`default_nettype none

module axiLiteRegs
#(
  parameter int gridSize = 4
)(
  input  logic                 clk,
  input  logic                 reset,
  input  logic [11:0]          awaddr,
  input  logic                 awvalid,
  output logic                 awready,
  input  logic [31:0]          wdata,
  input  logic                 wvalid,
  output logic                 wready,
  output drumPkg::axiResp_t    bresp,
  output logic                 bvalid,
  input  logic                 bready,
  input  logic [11:0]          araddr,
  input  logic                 arvalid,
  output logic                 arready,
  output logic [31:0]          rdata,
  output drumPkg::axiResp_t    rresp,
  output logic                 rvalid,
  input  logic                 rready,
  output drumPkg::sample_t     rho,
  output drumPkg::sample_t     eta,
  output drumPkg::strikeWord_t strikeWord,
  output logic                 clearReq,
  output logic                 strikeReq,
  output logic                 stepReq,
  output logic [15:0]          stepCount,
  input  logic [15:0]          remaining,
  input  logic                 busy,
  output logic [7:0]           readIndex,
  input  drumPkg::sample_t     readSample
);
  import drumPkg::*;

  localparam logic [11:0] nodeEnd = regNodeBase + 12'(4 * gridSize * gridSize);

  logic        writeFire;
  logic        readFire;
  logic        nodeHit;
  logic [11:0] nodeOffset;
  logic [31:0] readWord;

  assign writeFire = awvalid && awready && wvalid && wready;
  assign readFire  = arvalid && arready;
  assign arready   = !rvalid;
  assign bresp     = respOkay;
  assign rresp     = respOkay;

  // Node window decode
  assign nodeHit    = (araddr >= regNodeBase) && (araddr < nodeEnd);
  assign nodeOffset = araddr - regNodeBase;
  assign readIndex  = nodeOffset[9:2];

  always_comb
  begin
    readWord = '0;
    if (nodeHit)
      readWord = {{14{readSample[17]}}, readSample};
    else
    begin
      case (araddr)
        regSteps:  readWord = {16'd0, remaining};
        regRho:    readWord = {{14{rho[17]}}, rho};
        regEta:    readWord = {{14{eta[17]}}, eta};
        regStatus: readWord = {31'd0, busy};
        default:   readWord = '0;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      awready   <= 1'b0;
      wready    <= 1'b0;
      bvalid    <= 1'b0;
      rvalid    <= 1'b0;
      clearReq  <= 1'b0;
      strikeReq <= 1'b0;
      stepReq   <= 1'b0;
      rho       <= '0;
      eta       <= '0;
    end
    else
    begin
      clearReq  <= 1'b0;
      strikeReq <= 1'b0;
      stepReq   <= 1'b0;

      // Address and data taken together, one write at a time
      awready <= awvalid && wvalid && !awready && !bvalid;
      wready  <= awvalid && wvalid && !awready && !bvalid;

      if (writeFire)
      begin
        bvalid <= 1'b1;
        case (awaddr)
          regCtrl:   clearReq  <= wdata[0];
          regSteps:  stepReq   <= !busy && (wdata[15:0] != 16'd0);
          regStrike: strikeReq <= 1'b1;
          regRho:    rho       <= wdata[17:0];
          regEta:    eta       <= wdata[17:0];
          default:   ;
        endcase
      end
      else if (bvalid && bready)
        bvalid <= 1'b0;

      if (readFire)
        rvalid <= 1'b1;
      else if (rvalid && rready)
        rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (writeFire && awaddr == regSteps)
      stepCount <= wdata[15:0];
    if (writeFire && awaddr == regStrike)
      strikeWord.raw <= wdata;
    // rdata holds until the next accepted address
    if (readFire)
      rdata <= readWord;
  end

endmodule

`default_nettype wire

//--- hdl/drumTop.sv
`default_nettype none

module drumTop
#(
  parameter int gridSize = 4
)(
  input  logic              clk,
  input  logic              reset,
  input  logic [11:0]       awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [31:0]       wdata,
  input  logic              wvalid,
  output logic              wready,
  output drumPkg::axiResp_t bresp,
  output logic              bvalid,
  input  logic              bready,
  input  logic [11:0]       araddr,
  input  logic              arvalid,
  output logic              arready,
  output logic [31:0]       rdata,
  output drumPkg::axiResp_t rresp,
  output logic              rvalid,
  input  logic              rready
);
  import drumPkg::*;

  sample_t     rho;
  sample_t     eta;
  strikeWord_t strikeWord;
  logic        clearReq;
  logic        strikeReq;
  logic        stepReq;
  logic [15:0] stepCount;
  logic [15:0] remaining;
  logic        timerZero;
  logic        timerLoad;
  logic        timerDec;
  logic        busy;
  phase_t      phase;
  logic [3:0]  strikeX;
  logic [3:0]  strikeY;
  sample_t     strikeAmp;
  logic [7:0]  readIndex;
  sample_t     readSample;

  axiLiteRegs #(.gridSize(gridSize)) regs0
  (
    .clk, .reset,
    .awaddr, .awvalid, .awready,
    .wdata, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready,
    .rho, .eta, .strikeWord,
    .clearReq, .strikeReq, .stepReq, .stepCount,
    .remaining, .busy,
    .readIndex, .readSample
  );

  meshSequencer #(.gridSize(gridSize)) seq0
  (
    .clk, .reset,
    .clearReq, .strikeReq, .stepReq,
    .strikeWord, .timerZero,
    .phase, .strikeX, .strikeY, .strikeAmp,
    .timerLoad, .timerDec, .busy
  );

  stepTimer timer0
  (
    .clk, .reset,
    .timerLoad,
    .loadValue (stepCount),
    .timerDec,
    .remaining,
    .timerZero
  );

  nodeArray #(.gridSize(gridSize)) mesh0
  (
    .clk, .reset,
    .phase, .rho, .eta,
    .strikeX, .strikeY, .strikeAmp,
    .readIndex, .readSample
  );

endmodule

`default_nettype wire

//--- verification/drumCheck.svh
`ifndef DRUM_CHECK_SVH
`define DRUM_CHECK_SVH

// Prints the cause and ends the run
task automatic reportFailure(input string msg);
  $display("%s", msg);
  $display("Regression failed");
  $fatal(1);
endtask

// Node displacement from the read-back window
task automatic checkSample(input string name, input drumPkg::sample_t expected,
                           input drumPkg::sample_t actual);
  if (actual !== expected)
    reportFailure($sformatf("FAIL %s: expected %h, actual %h", name, expected, actual));
endtask

// Full 32-bit register word
task automatic checkWord(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
  if (actual !== expected)
    reportFailure($sformatf("FAIL %s: expected %h, actual %h", name, expected, actual));
endtask

// Every bus response must be OKAY
task automatic checkResp(input string name, input drumPkg::axiResp_t actual);
  if (actual !== drumPkg::respOkay)
    reportFailure($sformatf("FAIL %s response: expected %h, actual %h", name,
                            drumPkg::respOkay, actual));
endtask

`endif

//--- verification/drumTb.sv
`default_nettype none

module drumTb;
  timeunit 1ns;
  timeprecision 1ps;
  import drumPkg::*;

  logic        clk;
  logic        reset;
  logic [11:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic        wvalid;
  logic        wready;
  axiResp_t    bresp;
  logic        bvalid;
  logic        bready;
  logic [11:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  axiResp_t    rresp;
  logic        rvalid;
  logic        rready;

  int cycleCount = 0;
  int cycleLimit = 0;

  // One entry per vector line
  string       opList[$];
  string       nameList[$];
  logic [11:0] addrList[$];
  logic [31:0] dataList[$];
  logic [31:0] expList[$];

  `include "drumCheck.svh"

  drumTop #(.gridSize(4)) dut0
  (
    .clk, .reset,
    .awaddr, .awvalid, .awready,
    .wdata, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready
  );

  always #20 clk = ~clk;

  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleLimit > 0 && cycleCount >= cycleLimit)
      reportFailure($sformatf("Timeout: run did not finish within %0d cycles", cycleLimit));
  end

  task automatic loadVectors();
    int          fd;
    int          fields;
    string       line;
    string       op;
    string       name;
    logic [11:0] addr;
    logic [31:0] data;
    logic [31:0] expected;
    fd = $fopen("verification/drumVectors.txt", "r");
    if (fd == 0)
      reportFailure("Could not open the vector file verification/drumVectors.txt");
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line.substr(0, 0) != "#")
        begin
          fields = $sscanf(line, "%s %h %h %h %s", op, addr, data, expected, name);
          if (fields == 5)
          begin
            opList.push_back(op);
            addrList.push_back(addr);
            dataList.push_back(data);
            expList.push_back(expected);
            nameList.push_back(name);
            // Budget of 30 cycles per vector plus 4 per ordered step
            cycleLimit += 30;
            if (op == "W" && addr == regSteps)
              cycleLimit += 4 * int'(data[15:0]);
          end
          else if (fields > 0)
            reportFailure({"Malformed line in the vector file: ", line});
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic axiWrite(input string name, input logic [11:0] addr, input logic [31:0] data);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    while (!awready)
      @(negedge clk);
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid)
      @(negedge clk);
    checkResp(name, bresp);
    // Gives the request time to reach the sequencer
    repeat (2) @(negedge clk);
  endtask

  task automatic axiRead(input string name, input logic [11:0] addr, output logic [31:0] data);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    while (!arready)
      @(negedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    while (!rvalid)
      @(negedge clk);
    data = rdata;
    checkResp(name, rresp);
    @(negedge clk);
  endtask

  // Read with rready held low for a while after the address is taken
  task automatic stalledRead(input string name, input logic [11:0] addr,
                             output logic [31:0] data);
    logic [31:0] held;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b0;
    while (!arready)
      @(negedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    // Address moves on, the held read data must not follow it
    araddr  = (addr == regRho) ? regEta : regRho;
    while (!rvalid)
      @(negedge clk);
    held = rdata;
    repeat (6)
    begin
      @(negedge clk);
      if (!rvalid || rdata !== held)
        reportFailure({"Read data or rvalid changed while rready was low in ", name});
    end
    rready = 1'b1;
    data   = rdata;
    checkResp(name, rresp);
    @(negedge clk);
  endtask

  task automatic waitIdle(input string name);
    logic [31:0] status;
    status = 32'd1;
    while (status[0])
      axiRead(name, regStatus, status);
  endtask

  task automatic runVector(input int i);
    logic [31:0] actual;
    if (opList[i] == "W")
      axiWrite(nameList[i], addrList[i], dataList[i]);
    else if (opList[i] == "R" || opList[i] == "S")
    begin
      if (opList[i] == "R")
        axiRead(nameList[i], addrList[i], actual);
      else
        stalledRead(nameList[i], addrList[i], actual);
      if (addrList[i] >= regNodeBase)
        checkSample(nameList[i], expList[i][17:0], actual[17:0]);
      checkWord(nameList[i], expList[i], actual);
    end
    else if (opList[i] == "RNZ")
    begin
      axiRead(nameList[i], addrList[i], actual);
      if (actual == 32'd0)
        reportFailure($sformatf("FAIL %s: expected nonzero, actual %h", nameList[i], actual));
    end
    else if (opList[i] == "WAITIDLE")
      waitIdle(nameList[i]);
    else
      reportFailure({"Unknown operation in the vector file: ", opList[i]});
  endtask

  initial
  begin
    clk     = 1'b0;
    reset   = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    loadVectors();
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < opList.size(); i++)
      runVector(i);
    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/drumVectors.txt
# Columns: op address data expected name (hex fields, data unused on reads)
# op: W write, R read and compare, RNZ read nonzero, S stalled read, WAITIDLE poll status
R 014 0 0 statusAfterReset
R 00C 0 0 rhoAfterReset
R 010 0 0 etaAfterReset
R 040 0 0 node0AfterReset
R 07C 0 0 node15AfterReset
W 00C 3FFFF 0 rhoNegWrite
R 00C 0 FFFFFFFF rhoNegRead
W 010 20000 0 etaNegWrite
R 010 0 FFFE0000 etaNegRead
R 020 0 0 unmappedRead
W 008 0087C000 0 strikeNeg
WAITIDLE 0 0 0 strikeNegDone
R 064 0 FFFFC000 strikeNode
R 060 0 0 strikeLeftNeighbour
R 054 0 0 strikeUpperNeighbour
W 008 00150000 0 strikeOutside
WAITIDLE 0 0 0 strikeOutsideDone
R 054 0 0 outsideNoChange
R 064 0 FFFFC000 outsideKeepsStrike
W 000 1 0 clearBeforeStep
W 00C 8000 0 rhoQuarter
W 010 0 0 etaZero
W 008 00444000 0 strikeCentre
WAITIDLE 0 0 0 strikeCentreDone
W 004 1 0 oneStep
WAITIDLE 0 0 0 oneStepDone
R 054 0 4000 centreAfterStep
R 044 0 FFF northAfterStep
R 050 0 FFF westAfterStep
R 058 0 FFF eastAfterStep
R 064 0 FFF southAfterStep
R 040 0 0 diagonalAfterStep
R 068 0 0 farDiagonalAfterStep
W 000 1 0 clearBeforeRun
W 010 10000 0 etaHalf
W 008 00004000 0 strikeCorner
WAITIDLE 0 0 0 strikeCornerDone
W 004 5 0 fiveSteps
RNZ 014 0 0 busyDuringRun
RNZ 004 0 0 remainingDuringRun
W 004 9 0 stepsWhileBusy
WAITIDLE 0 0 0 fiveStepsDone
R 004 0 0 remainingAfterRun
R 040 0 B0AC cornerAfterFive
R 044 0 7161 edgeXAfterFive
R 050 0 7161 edgeYAfterFive
R 04C 0 296 farEdgeAfterFive
R 068 0 B4 innerAfterFive
R 07C 0 0 oppositeCornerAfterFive
W 000 1 0 clearMesh
R 040 0 0 cornerAfterClear
R 044 0 0 edgeAfterClear
R 050 0 0 otherEdgeAfterClear
W 004 1 0 stepAfterClear
WAITIDLE 0 0 0 stepAfterClearDone
R 040 0 0 cornerStaysZero
R 054 0 0 innerStaysZero
W 008 00CC4000 0 strikeFarCorner
WAITIDLE 0 0 0 strikeFarCornerDone
W 004 1 0 stepBeforeStall
S 040 0 0 stalledNodeRead
WAITIDLE 0 0 0 stepBeforeStallDone
R 07C 0 6000 farCornerAfterStep
R 078 0 800 farWestAfterStep
R 06C 0 800 farNorthAfterStep

//--- filelist.f
+incdir+verification
common/drumPkg.sv
mesh/compNode.sv
mesh/nodeArray.sv
hdl/stepTimer.sv
hdl/meshSequencer.sv
hdl/axiLiteRegs.sv
hdl/drumTop.sv
verification/drumTb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = drumTb
FILELIST  = filelist.f
OBJDIR    = obj_dir
PASS_MSG  = Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
